// File: hw/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus population
`define NR_MASTER 2
`define NR_SLAVE  4

// Address map, sizes in bytes
`define RAM_BASE        32'h00000000
`define RAM_SIZE_BYTES  1024
`define GPIO0_BASE      32'h10000000
`define GPIO1_BASE      32'h10000010
`define GPIO_SIZE       16
`define RESET_CTRL_BASE 32'h10000030
`define RESET_CTRL_SIZE 8

// Reset timing in sys_clk cycles
`define POR_CYCLES         16
`define RESET_PULSE_CYCLES 4

`endif

// File: hw/soc_pkg.sv
package soc_pkg;

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;   // One bit per byte lane

  // Slave ports of the shared bus, also the result of the address decode
  typedef enum logic [1:0] {
    RAM_S        = 2'd0,
    GPIO0_S      = 2'd1,
    GPIO1_S      = 2'd2,
    RESET_CTRL_S = 2'd3
  } slave_e;

  typedef enum logic {
    M0_M = 1'b0,  // Wins arbitration ties
    M1_M = 1'b1
  } master_e;

endpackage

// File: hw/wb_shared_bus.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module wb_shared_bus (
  input  logic                  sys_clk,
  input  logic                  rst_i,
  input  logic                  dm_reset_i,
  // Master side, indexed by master_e
  input  logic [`NR_MASTER-1:0] m_cyc_i,
  input  logic [`NR_MASTER-1:0] m_stb_i,
  input  logic [`NR_MASTER-1:0] m_we_i,
  input  soc_pkg::addr_t        m_adr_i [`NR_MASTER],
  input  soc_pkg::data_t        m_dat_i [`NR_MASTER],
  input  soc_pkg::sel_t         m_sel_i [`NR_MASTER],
  output logic [`NR_MASTER-1:0] m_stall_o,
  output logic [`NR_MASTER-1:0] m_ack_o,
  output logic [`NR_MASTER-1:0] m_err_o,
  output soc_pkg::data_t        m_dat_o [`NR_MASTER],
  // Slave side, indexed by slave_e
  output logic [`NR_SLAVE-1:0]  s_cyc_o,
  output logic [`NR_SLAVE-1:0]  s_stb_o,
  output logic [`NR_SLAVE-1:0]  s_we_o,
  output soc_pkg::addr_t        s_adr_o [`NR_SLAVE],
  output soc_pkg::data_t        s_dat_o [`NR_SLAVE],
  output soc_pkg::sel_t         s_sel_o [`NR_SLAVE],
  input  logic [`NR_SLAVE-1:0]  s_ack_i,
  input  soc_pkg::data_t        s_dat_i [`NR_SLAVE]
);
  import soc_pkg::*;

  logic                  bus_rst;
  logic [`NR_MASTER-1:0] grant_q;
  logic [`NR_MASTER-1:0] grant_d;
  master_e               owner;
  logic                  acc;      // Owner's request accepted this cycle
  logic                  dec_hit;
  slave_e                dec_slave;
  slave_e                resp_slave_q;
  logic                  err_q;

  function automatic logic in_window(addr_t adr, addr_t base, int unsigned size);
    return (adr - base) < size;  // Addresses below base wrap to large offsets
  endfunction

  assign bus_rst = rst_i | dm_reset_i;

  // Owner keeps the bus while its cyc is high, else lowest index wins
  always_comb begin
    grant_d = grant_q;
    if ((grant_q & m_cyc_i) == '0) begin
      grant_d = '0;
      for (int m = `NR_MASTER - 1; m >= 0; m--) begin
        if (m_cyc_i[m]) begin
          grant_d    = '0;
          grant_d[m] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    owner = M0_M;
    for (int m = 0; m < `NR_MASTER; m++) begin
      if (grant_q[m]) owner = master_e'(m);
    end
  end

  assign acc = (|grant_q) & m_cyc_i[owner] & m_stb_i[owner];

  always_comb begin
    dec_hit   = 1'b1;
    dec_slave = RAM_S;
    if (in_window(m_adr_i[owner], `RAM_BASE, `RAM_SIZE_BYTES)) begin
      dec_slave = RAM_S;
    end else if (in_window(m_adr_i[owner], `GPIO0_BASE, `GPIO_SIZE)) begin
      dec_slave = GPIO0_S;
    end else if (in_window(m_adr_i[owner], `GPIO1_BASE, `GPIO_SIZE)) begin
      dec_slave = GPIO1_S;
    end else if (in_window(m_adr_i[owner], `RESET_CTRL_BASE, `RESET_CTRL_SIZE)) begin
      dec_slave = RESET_CTRL_S;
    end else begin
      dec_hit = 1'b0;  // Unmapped
    end
  end

  // Request goes to the decoded slave only, payload is shared
  always_comb begin
    for (int s = 0; s < `NR_SLAVE; s++) begin
      s_cyc_o[s] = (|grant_q) & m_cyc_i[owner] & dec_hit & (dec_slave == slave_e'(s));
      s_stb_o[s] = acc & dec_hit & (dec_slave == slave_e'(s));
      s_we_o[s]  = m_we_i[owner];
      s_adr_o[s] = m_adr_i[owner];
      s_dat_o[s] = m_dat_i[owner];
      s_sel_o[s] = m_sel_i[owner];
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus_rst) begin
      grant_q <= '0;
      err_q   <= 1'b0;
    end else begin
      grant_q <= grant_d;
      err_q   <= acc & ~dec_hit;  // Bus answers unmapped accesses itself
    end
  end

  // Remembers which slave owes the next response
  always_ff @(posedge sys_clk) begin
    if (acc) begin
      resp_slave_q <= dec_slave;
    end
  end

  // Grant cannot move between accept and response, so it routes the response
  always_comb begin
    for (int m = 0; m < `NR_MASTER; m++) begin
      m_stall_o[m] = ~grant_q[m];
      m_ack_o[m]   = grant_q[m] & (|s_ack_i);
      m_err_o[m]   = grant_q[m] & err_q;
      m_dat_o[m]   = s_dat_i[resp_slave_q];
    end
  end

  a_grant_onehot: assert property (@(posedge sys_clk) disable iff (bus_rst)
    $onehot0(grant_q));

  a_ack_err_excl: assert property (@(posedge sys_clk) disable iff (bus_rst)
    (m_ack_o & m_err_o) == '0);

  a_resp_after_req: assert property (@(posedge sys_clk) disable iff (bus_rst)
    (|m_ack_o || |m_err_o) |-> $past(acc));

endmodule

// File: hw/wb_ram.sv
`timescale 1ns/1ps

module wb_ram #(
  parameter int SIZE_BYTES = 1024
) (
  input  logic        sys_clk,
  input  logic        ndm_reset_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic        ack_o,
  output logic [31:0] dat_o
);
  localparam int WORDS = SIZE_BYTES / 4;
  localparam int AW    = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] word_idx;
  logic          req;

  assign word_idx = adr_i[AW+1:2];  // Byte offset bits dropped
  assign req      = cyc_i & stb_i;

  always_ff @(posedge sys_clk) begin
    if (req) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
      dat_o <= mem[word_idx];  // Old contents on a write
    end
  end

  always_ff @(posedge sys_clk) begin
    if (ndm_reset_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;
    end
  end

endmodule

// File: hw/wb_gpio.sv
`timescale 1ns/1ps

module wb_gpio #(
  parameter int WIDTH = 8
) (
  input  logic             sys_clk,
  input  logic             ndm_reset_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  logic [31:0]      adr_i,
  input  logic [31:0]      dat_i,
  input  logic [3:0]       sel_i,
  output logic             ack_o,
  output logic [31:0]      dat_o,
  output logic [WIDTH-1:0] gpio_o,
  output logic [WIDTH-1:0] gpio_oe_o,
  input  logic [WIDTH-1:0] gpio_i
);
  logic [WIDTH-1:0] out_q;
  logic [WIDTH-1:0] oe_q;
  logic [WIDTH-1:0] sync1_q;
  logic [WIDTH-1:0] sync2_q;
  logic [WIDTH-1:0] out_d;
  logic [WIDTH-1:0] oe_d;
  logic [31:0]      wmask;
  logic [31:0]      rd_d;
  logic             wr;

  assign wr    = cyc_i & stb_i & we_i;
  assign wmask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

  // Byte lanes without a select keep their old value
  assign out_d = (out_q & ~wmask[WIDTH-1:0]) | (dat_i[WIDTH-1:0] & wmask[WIDTH-1:0]);
  assign oe_d  = (oe_q & ~wmask[WIDTH-1:0]) | (dat_i[WIDTH-1:0] & wmask[WIDTH-1:0]);

  always_comb begin
    rd_d = '0;  // Bits above WIDTH read zero
    case (adr_i[3:2])
      2'd0:    rd_d[WIDTH-1:0] = out_q;
      2'd1:    rd_d[WIDTH-1:0] = oe_q;
      2'd2:    rd_d[WIDTH-1:0] = sync2_q;  // Pin state
      default: rd_d = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (ndm_reset_i) begin
      out_q <= '0;
      oe_q  <= '0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= cyc_i & stb_i;
      if (wr && adr_i[3:2] == 2'd0) out_q <= out_d;
      if (wr && adr_i[3:2] == 2'd1) oe_q <= oe_d;
    end
  end

  always_ff @(posedge sys_clk) begin
    sync1_q <= gpio_i;  // Pins are asynchronous
    sync2_q <= sync1_q;
    dat_o   <= rd_d;
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

endmodule

// File: hw/reset_ctrl.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_ctrl (
  input  logic           sys_clk,
  input  logic           rst_i,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  input  soc_pkg::sel_t  sel_i,
  output logic           ack_o,
  output soc_pkg::data_t dat_o,
  output logic           ndm_reset_o,
  output logic           dm_reset_o,
  output logic           por_completed_o
);
  import soc_pkg::*;

  localparam int POR_W   = $clog2(`POR_CYCLES + 1);
  localparam int PULSE_W = $clog2(`RESET_PULSE_CYCLES + 1);

  logic [POR_W-1:0]   por_cnt_q;
  logic               por_done_q;
  logic               por_fire;
  logic [PULSE_W-1:0] ndm_cnt_q;
  logic [PULSE_W-1:0] dm_cnt_q;
  logic [1:0]         req_q;     // Requested resets, start after the ack
  logic [2:0]         reason_q;  // {dm, ndm, power-on}
  logic               wr_ctrl;
  logic               wr_reason;
  data_t              rd_d;

  assign wr_ctrl   = cyc_i & stb_i & we_i & ~adr_i[2];
  assign wr_reason = cyc_i & stb_i & we_i & adr_i[2];
  assign por_fire  = ~por_done_q & (por_cnt_q == POR_W'(`POR_CYCLES - 1));

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      por_cnt_q  <= '0;
      por_done_q <= 1'b0;
    end else if (!por_done_q) begin
      por_cnt_q  <= por_cnt_q + 1'b1;
      por_done_q <= por_fire;
    end
  end

  // Only rst_i clears this, the requested pulses must not eat their own ack
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_o     <= 1'b0;
      req_q     <= '0;
      ndm_cnt_q <= '0;
      dm_cnt_q  <= '0;
      reason_q  <= '0;
    end else begin
      ack_o <= cyc_i & stb_i;
      req_q <= (wr_ctrl & sel_i[0]) ? dat_i[1:0] : 2'b00;

      if (req_q[0]) begin
        ndm_cnt_q <= PULSE_W'(`RESET_PULSE_CYCLES);
      end else if (ndm_cnt_q != '0) begin
        ndm_cnt_q <= ndm_cnt_q - 1'b1;
      end

      if (req_q[1]) begin
        dm_cnt_q <= PULSE_W'(`RESET_PULSE_CYCLES);
      end else if (dm_cnt_q != '0) begin
        dm_cnt_q <= dm_cnt_q - 1'b1;
      end

      if (wr_reason) begin
        reason_q <= '0;  // Any write clears
      end else begin
        reason_q <= reason_q | {req_q[1], req_q[0], por_fire};
      end
    end
  end

  always_comb begin
    rd_d = '0;
    if (adr_i[2]) begin
      rd_d[2:0] = reason_q;
    end else begin
      rd_d[1:0] = {dm_reset_o, ndm_reset_o};  // Live reset state
    end
  end

  always_ff @(posedge sys_clk) begin
    dat_o <= rd_d;
  end

  assign ndm_reset_o     = ~por_done_q | (ndm_cnt_q != '0);
  assign dm_reset_o      = ~por_done_q | (dm_cnt_q != '0);
  assign por_completed_o = por_done_q;

endmodule

// File: hw/soc_top.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top (
  input  logic           sys_clk,
  input  logic           rst_i,
  // Master 0, highest priority
  input  logic           m0_cyc_i,
  input  logic           m0_stb_i,
  input  logic           m0_we_i,
  input  soc_pkg::addr_t m0_adr_i,
  input  soc_pkg::data_t m0_dat_i,
  input  soc_pkg::sel_t  m0_sel_i,
  output logic           m0_stall_o,
  output logic           m0_ack_o,
  output logic           m0_err_o,
  output soc_pkg::data_t m0_dat_o,
  // Master 1
  input  logic           m1_cyc_i,
  input  logic           m1_stb_i,
  input  logic           m1_we_i,
  input  soc_pkg::addr_t m1_adr_i,
  input  soc_pkg::data_t m1_dat_i,
  input  soc_pkg::sel_t  m1_sel_i,
  output logic           m1_stall_o,
  output logic           m1_ack_o,
  output logic           m1_err_o,
  output soc_pkg::data_t m1_dat_o,
  // GPIO pins
  output logic [7:0]     gpio0_o,
  output logic [7:0]     gpio0_oe_o,
  input  logic [7:0]     gpio0_i,
  output logic [3:0]     gpio1_o,
  output logic [3:0]     gpio1_oe_o,
  input  logic [3:0]     gpio1_i,
  output logic           por_completed_o
);
  import soc_pkg::*;

  logic ndm_reset;  // Everything but the bus
  logic dm_reset;

  logic [`NR_MASTER-1:0] m_cyc, m_stb, m_we, m_stall, m_ack, m_err;
  addr_t                 m_adr [`NR_MASTER];
  data_t                 m_dat_w [`NR_MASTER];
  data_t                 m_dat_r [`NR_MASTER];
  sel_t                  m_sel [`NR_MASTER];

  logic [`NR_SLAVE-1:0]  s_cyc, s_stb, s_we, s_ack;
  addr_t                 s_adr [`NR_SLAVE];
  data_t                 s_dat_w [`NR_SLAVE];
  data_t                 s_dat_r [`NR_SLAVE];
  sel_t                  s_sel [`NR_SLAVE];

  // Index 0 is M0_M
  assign m_cyc   = {m1_cyc_i, m0_cyc_i};
  assign m_stb   = {m1_stb_i, m0_stb_i};
  assign m_we    = {m1_we_i, m0_we_i};
  assign m_adr   = '{m0_adr_i, m1_adr_i};
  assign m_dat_w = '{m0_dat_i, m1_dat_i};
  assign m_sel   = '{m0_sel_i, m1_sel_i};

  assign {m1_stall_o, m0_stall_o} = m_stall;
  assign {m1_ack_o, m0_ack_o}     = m_ack;
  assign {m1_err_o, m0_err_o}     = m_err;
  assign m0_dat_o = m_dat_r[M0_M];
  assign m1_dat_o = m_dat_r[M1_M];

  wb_shared_bus u_bus (
    .sys_clk    (sys_clk),
    .rst_i      (rst_i),
    .dm_reset_i (dm_reset),
    .m_cyc_i    (m_cyc),
    .m_stb_i    (m_stb),
    .m_we_i     (m_we),
    .m_adr_i    (m_adr),
    .m_dat_i    (m_dat_w),
    .m_sel_i    (m_sel),
    .m_stall_o  (m_stall),
    .m_ack_o    (m_ack),
    .m_err_o    (m_err),
    .m_dat_o    (m_dat_r),
    .s_cyc_o    (s_cyc),
    .s_stb_o    (s_stb),
    .s_we_o     (s_we),
    .s_adr_o    (s_adr),
    .s_dat_o    (s_dat_w),
    .s_sel_o    (s_sel),
    .s_ack_i    (s_ack),
    .s_dat_i    (s_dat_r)
  );

  wb_ram #(
    .SIZE_BYTES (`RAM_SIZE_BYTES)
  ) u_ram (
    .sys_clk     (sys_clk),
    .ndm_reset_i (ndm_reset),
    .cyc_i       (s_cyc[RAM_S]),
    .stb_i       (s_stb[RAM_S]),
    .we_i        (s_we[RAM_S]),
    .adr_i       (s_adr[RAM_S]),
    .dat_i       (s_dat_w[RAM_S]),
    .sel_i       (s_sel[RAM_S]),
    .ack_o       (s_ack[RAM_S]),
    .dat_o       (s_dat_r[RAM_S])
  );

  wb_gpio #(
    .WIDTH (8)
  ) u_gpio0 (
    .sys_clk     (sys_clk),
    .ndm_reset_i (ndm_reset),
    .cyc_i       (s_cyc[GPIO0_S]),
    .stb_i       (s_stb[GPIO0_S]),
    .we_i        (s_we[GPIO0_S]),
    .adr_i       (s_adr[GPIO0_S]),
    .dat_i       (s_dat_w[GPIO0_S]),
    .sel_i       (s_sel[GPIO0_S]),
    .ack_o       (s_ack[GPIO0_S]),
    .dat_o       (s_dat_r[GPIO0_S]),
    .gpio_o      (gpio0_o),
    .gpio_oe_o   (gpio0_oe_o),
    .gpio_i      (gpio0_i)
  );

  wb_gpio #(
    .WIDTH (4)
  ) u_gpio1 (
    .sys_clk     (sys_clk),
    .ndm_reset_i (ndm_reset),
    .cyc_i       (s_cyc[GPIO1_S]),
    .stb_i       (s_stb[GPIO1_S]),
    .we_i        (s_we[GPIO1_S]),
    .adr_i       (s_adr[GPIO1_S]),
    .dat_i       (s_dat_w[GPIO1_S]),
    .sel_i       (s_sel[GPIO1_S]),
    .ack_o       (s_ack[GPIO1_S]),
    .dat_o       (s_dat_r[GPIO1_S]),
    .gpio_o      (gpio1_o),
    .gpio_oe_o   (gpio1_oe_o),
    .gpio_i      (gpio1_i)
  );

  reset_ctrl u_reset_ctrl (
    .sys_clk         (sys_clk),
    .rst_i           (rst_i),
    .cyc_i           (s_cyc[RESET_CTRL_S]),
    .stb_i           (s_stb[RESET_CTRL_S]),
    .we_i            (s_we[RESET_CTRL_S]),
    .adr_i           (s_adr[RESET_CTRL_S]),
    .dat_i           (s_dat_w[RESET_CTRL_S]),
    .sel_i           (s_sel[RESET_CTRL_S]),
    .ack_o           (s_ack[RESET_CTRL_S]),
    .dat_o           (s_dat_r[RESET_CTRL_S]),
    .ndm_reset_o     (ndm_reset),
    .dm_reset_o      (dm_reset),
    .por_completed_o (por_completed_o)
  );

endmodule

// File: verif/tb_soc.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc;
  import soc_pkg::*;

  localparam int ACCEPT_TIMEOUT = 100;  // Cycles a master waits for its grant
  localparam int RESP_TIMEOUT   = 20;
  localparam int POR_TIMEOUT    = 100;
  localparam int POLL_TIMEOUT   = 20;
  localparam int ARB_TIMEOUT    = 600;  // Master 0 burst in the priority test

  logic       sys_clk;
  logic       rst_i;
  logic       m0_cyc_i;
  logic       m0_stb_i;
  logic       m0_we_i;
  addr_t      m0_adr_i;
  data_t      m0_dat_i;
  sel_t       m0_sel_i;
  logic       m0_stall_o;
  logic       m0_ack_o;
  logic       m0_err_o;
  data_t      m0_dat_o;
  logic       m1_cyc_i;
  logic       m1_stb_i;
  logic       m1_we_i;
  addr_t      m1_adr_i;
  data_t      m1_dat_i;
  sel_t       m1_sel_i;
  logic       m1_stall_o;
  logic       m1_ack_o;
  logic       m1_err_o;
  data_t      m1_dat_o;
  logic [7:0] gpio0_o;
  logic [7:0] gpio0_oe_o;
  logic [7:0] gpio0_i;
  logic [3:0] gpio1_o;
  logic [3:0] gpio1_oe_o;
  logic [3:0] gpio1_i;
  logic       por_completed_o;

  logic [31:0] lfsr_q;
  data_t       ref_mem [256];  // Expected RAM contents by word index
  int          ram_idx [8];    // Words written by the RAM test
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;

  soc_top u_dut (.*);

  initial sys_clk = 1'b0;
  always #2 sys_clk = ~sys_clk;

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) s = s ^ 32'h8020_0003;
    return s;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit taken
    end
    return v;
  endfunction

  // Register value after a byte-select write with bits above width cleared
  function automatic data_t apply_write(data_t old, data_t wdat, sel_t sel, int width);
    data_t lane;
    data_t keep;
    lane = '0;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) lane[8*b +: 8] = 8'hff;
    end
    keep = (width >= 32) ? '1 : ((data_t'(1) << width) - data_t'(1));
    return ((old & ~lane) | (wdat & lane)) & keep;
  endfunction

  function automatic string port_name(master_e m, string sig);
    return $sformatf("m%0d_%s", m, sig);
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic drive_req(input master_e m, input logic cyc, input logic stb, input logic we,
                           input addr_t adr, input data_t dat, input sel_t sel);
    case (m)
      M0_M: begin
        m0_cyc_i = cyc;
        m0_stb_i = stb;
        m0_we_i  = we;
        m0_adr_i = adr;
        m0_dat_i = dat;
        m0_sel_i = sel;
      end
      default: begin
        m1_cyc_i = cyc;
        m1_stb_i = stb;
        m1_we_i  = we;
        m1_adr_i = adr;
        m1_dat_i = dat;
        m1_sel_i = sel;
      end
    endcase
  endtask

  // One Wishbone access that leaves cyc high when hold is set
  task automatic bus_access(input master_e m, input logic we, input addr_t adr,
                            input data_t wdat, input sel_t sel, input logic hold,
                            output data_t rdat, output logic got_ack, output logic got_err);
    int   waited;
    logic stall;
    rdat    = '0;
    got_ack = 1'b0;
    got_err = 1'b0;
    @(posedge sys_clk);
    #1;
    drive_req(m, 1'b1, 1'b1, we, adr, wdat, sel);
    waited = 0;
    stall  = 1'b1;
    while (stall && waited < ACCEPT_TIMEOUT) begin
      @(negedge sys_clk);
      stall = (m == M0_M) ? m0_stall_o : m1_stall_o;
      waited++;
    end
    if (stall) begin
      $display("Master %0d request to %h was never accepted", m, adr);
      errors++;
      @(posedge sys_clk);
      #1;
      drive_req(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
      return;
    end
    @(posedge sys_clk);  // Request taken on this edge
    #1;
    drive_req(m, 1'b1, 1'b0, we, adr, wdat, sel);
    waited = 0;
    while (!got_ack && !got_err && waited < RESP_TIMEOUT) begin
      @(negedge sys_clk);
      got_ack = (m == M0_M) ? m0_ack_o : m1_ack_o;
      got_err = (m == M0_M) ? m0_err_o : m1_err_o;
      rdat    = (m == M0_M) ? m0_dat_o : m1_dat_o;
      waited++;
    end
    if (!got_ack && !got_err) begin
      $display("Master %0d got no response for address %h", m, adr);
      errors++;
    end else begin
      check_bit(port_name(m, "response in cycle after accept"), waited == 1, 1'b1);
    end
    if (!hold) begin
      @(posedge sys_clk);
      #1;
      drive_req(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    end
  endtask

  task automatic write_word(input master_e m, input addr_t adr, input data_t wdat,
                            input sel_t sel);
    data_t rd;
    logic  ack;
    logic  err;
    bus_access(m, 1'b1, adr, wdat, sel, 1'b0, rd, ack, err);
    check_bit(port_name(m, "ack_o"), ack, 1'b1);
  endtask

  task automatic read_word(input master_e m, input addr_t adr, output data_t rd);
    logic ack;
    logic err;
    bus_access(m, 1'b0, adr, '0, 4'hf, 1'b0, rd, ack, err);
    check_bit(port_name(m, "ack_o"), ack, 1'b1);
  endtask

  task automatic read_check(input master_e m, input addr_t adr, input data_t exp);
    data_t rd;
    read_word(m, adr, rd);
    check_data($sformatf("m%0d_dat_o @%h", m, adr), rd, exp);
  endtask

  task automatic report_test(input string name, input int mark);
    tests++;
    if (errors == mark) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - mark);
  endtask

  task automatic por_timing();
    int cycles;
    rst_i = 1'b1;
    repeat (3) @(posedge sys_clk);
    #1;
    check_bit("m0_stall_o", m0_stall_o, 1'b1);
    check_bit("m1_stall_o", m1_stall_o, 1'b1);
    check_bit("m0_ack_o", m0_ack_o, 1'b0);
    check_bit("m1_err_o", m1_err_o, 1'b0);
    check_bit("por_completed_o", por_completed_o, 1'b0);
    check_data("gpio0_o", {24'h0, gpio0_o}, '0);
    check_data("gpio1_oe_o", {28'h0, gpio1_oe_o}, '0);
    rst_i  = 1'b0;
    cycles = 0;
    while (!por_completed_o && cycles < POR_TIMEOUT) begin
      @(posedge sys_clk);
      cycles++;
      @(negedge sys_clk);
    end
    if (!por_completed_o) begin
      $display("Power-on reset never completed");
      errors++;
    end else begin
      check_data("por_completed_o delay", data_t'(cycles), data_t'(`POR_CYCLES));
    end
    read_check(M0_M, `RESET_CTRL_BASE + 32'd4, 32'h1);  // Power-on reason
  endtask

  task automatic ram_random_rw();
    data_t wdat;
    sel_t  sel;
    for (int i = 0; i < 8; i++) begin
      ram_idx[i] = int'(rand_bits(7));
      wdat = rand_bits(32);
      write_word((i % 2 == 0) ? M0_M : M1_M, addr_t'(ram_idx[i] * 4), wdat, 4'hf);
      ref_mem[ram_idx[i]] = apply_write(ref_mem[ram_idx[i]], wdat, 4'hf, 32);
    end
    for (int i = 0; i < 8; i++) begin
      wdat = rand_bits(32);
      sel  = sel_t'(rand_bits(4));
      write_word((i % 2 == 0) ? M1_M : M0_M, addr_t'(ram_idx[i] * 4), wdat, sel);
      ref_mem[ram_idx[i]] = apply_write(ref_mem[ram_idx[i]], wdat, sel, 32);
    end
    for (int i = 0; i < 8; i++) begin
      read_check((i % 2 == 0) ? M0_M : M1_M, addr_t'(ram_idx[i] * 4), ref_mem[ram_idx[i]]);
    end
  endtask

  task automatic gpio_pins();
    data_t w;
    data_t exp0;
    data_t exp0_oe;
    data_t exp1;
    data_t exp1_oe;
    w = rand_bits(32);
    write_word(M0_M, `GPIO0_BASE, w, 4'hf);
    exp0 = apply_write('0, w, 4'hf, 8);
    w = rand_bits(32);
    write_word(M1_M, `GPIO0_BASE + 32'd4, w, 4'hf);
    exp0_oe = apply_write('0, w, 4'hf, 8);
    w = rand_bits(32);
    write_word(M0_M, `GPIO1_BASE, w, 4'hf);
    exp1 = apply_write('0, w, 4'hf, 4);
    w = rand_bits(32);
    write_word(M1_M, `GPIO1_BASE + 32'd4, w, 4'hf);
    exp1_oe = apply_write('0, w, 4'hf, 4);
    w = rand_bits(32);
    write_word(M0_M, `GPIO0_BASE, w, 4'he);  // Low byte not selected
    exp0 = apply_write(exp0, w, 4'he, 8);
    check_data("gpio0_o", {24'h0, gpio0_o}, exp0);
    check_data("gpio0_oe_o", {24'h0, gpio0_oe_o}, exp0_oe);
    check_data("gpio1_o", {28'h0, gpio1_o}, exp1);
    check_data("gpio1_oe_o", {28'h0, gpio1_oe_o}, exp1_oe);
    read_check(M1_M, `GPIO0_BASE, exp0);
    read_check(M0_M, `GPIO1_BASE + 32'd4, exp1_oe);
    @(posedge sys_clk);
    #1;
    gpio0_i = 8'(rand_bits(8));
    gpio1_i = 4'(rand_bits(4));
    repeat (2) @(posedge sys_clk);  // Two-flop synchronizer
    read_check(M0_M, `GPIO0_BASE + 32'd8, {24'h0, gpio0_i});
    read_check(M1_M, `GPIO1_BASE + 32'd8, {28'h0, gpio1_i});
    read_check(M0_M, `GPIO0_BASE + 32'd12, '0);
  endtask

  task automatic unmapped_error();
    data_t rd;
    logic  ack;
    logic  err;
    bus_access(M0_M, 1'b0, 32'h2000_0000, '0, 4'hf, 1'b0, rd, ack, err);
    check_bit("m0_err_o", err, 1'b1);
    check_bit("m0_ack_o", ack, 1'b0);
    bus_access(M1_M, 1'b1, 32'h1000_0020, rand_bits(32), 4'hf, 1'b0, rd, ack, err);
    check_bit("m1_err_o", err, 1'b1);
    check_bit("m1_ack_o", ack, 1'b0);
    @(negedge sys_clk);
    check_bit("m1_ack_o", m1_ack_o, 1'b0);  // No late ack either
    check_bit("m1_err_o", m1_err_o, 1'b0);
    read_check(M0_M, addr_t'(ram_idx[0] * 4), ref_mem[ram_idx[0]]);
  endtask

  task automatic master_priority();
    data_t wdat [4];
    data_t rd0;
    data_t rd1;
    logic  ack0;
    logic  err0;
    logic  ack1;
    logic  err1;
    logic  m0_done;
    int    arb_cycles;
    m0_done    = 1'b0;
    arb_cycles = 0;
    for (int i = 0; i < 4; i++) begin
      wdat[i] = rand_bits(32);
    end
    fork
      begin
        for (int i = 0; i < 4; i++) begin
          bus_access(M0_M, 1'b1, addr_t'((200 + i) * 4), wdat[i], 4'hf, i < 3,
                     rd0, ack0, err0);
          check_bit("m0_ack_o", ack0, 1'b1);
          ref_mem[200 + i] = apply_write(ref_mem[200 + i], wdat[i], 4'hf, 32);
        end
        m0_done = 1'b1;
      end
      begin
        for (int i = 0; i < 4; i++) begin
          bus_access(M1_M, 1'b0, addr_t'((200 + i) * 4), '0, 4'hf, i < 3, rd1, ack1, err1);
          check_bit("m1_ack_o", ack1, 1'b1);
          check_data($sformatf("m1_dat_o @%h", (200 + i) * 4), rd1, ref_mem[200 + i]);
        end
      end
      begin
        // Master 1 is held off for as long as master 0 keeps cyc
        while (!m0_done && arb_cycles < ARB_TIMEOUT) begin
          @(negedge sys_clk);
          arb_cycles++;
          if (!m0_done) check_bit("m1_stall_o", m1_stall_o, 1'b1);
        end
        if (!m0_done) begin
          $display("Master 0 did not finish its accesses in time");
          errors++;
        end
      end
    join
  endtask

  task automatic reset_request();
    data_t rd;
    int    polls;
    write_word(M1_M, `GPIO0_BASE, 32'ha5, 4'hf);
    write_word(M1_M, `GPIO1_BASE + 32'd4, 32'hf, 4'hf);
    check_data("gpio0_o", {24'h0, gpio0_o}, 32'ha5);
    write_word(M0_M, `RESET_CTRL_BASE, 32'h1, 4'h1);
    polls = 0;
    rd    = 32'h1;
    while (rd[0] && polls < POLL_TIMEOUT) begin
      read_word(M0_M, `RESET_CTRL_BASE, rd);  // Live ndm reset state
      polls++;
    end
    if (rd[0]) begin
      $display("Requested ndm reset did not end");
      errors++;
    end
    check_data("gpio0_o", {24'h0, gpio0_o}, '0);
    check_data("gpio0_oe_o", {24'h0, gpio0_oe_o}, '0);
    check_data("gpio1_o", {28'h0, gpio1_o}, '0);
    check_data("gpio1_oe_o", {28'h0, gpio1_oe_o}, '0);
    for (int i = 0; i < 8; i++) begin
      read_check(M1_M, addr_t'(ram_idx[i] * 4), ref_mem[ram_idx[i]]);
    end
    read_check(M0_M, `RESET_CTRL_BASE + 32'd4, 32'h3);  // Sticky power-on plus ndm
    write_word(M0_M, `RESET_CTRL_BASE + 32'd4, 32'h0, 4'hf);
    read_check(M0_M, `RESET_CTRL_BASE + 32'd4, 32'h0);
  endtask

  initial begin
    lfsr_q = 32'h9ec9;
    errors = 0;
    checks = 0;
    tests  = 0;
    rst_i  = 1'b1;
    drive_req(M0_M, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    drive_req(M1_M, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    gpio0_i = '0;
    gpio1_i = '0;

    err_mark = errors;
    por_timing();
    report_test("power-on reset", err_mark);
    err_mark = errors;
    ram_random_rw();
    report_test("ram access", err_mark);
    err_mark = errors;
    gpio_pins();
    report_test("gpio", err_mark);
    err_mark = errors;
    unmapped_error();
    report_test("unmapped address", err_mark);
    err_mark = errors;
    master_priority();
    report_test("arbitration", err_mark);
    err_mark = errors;
    reset_request();
    report_test("requested reset", err_mark);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/soc_pkg.sv
hw/wb_shared_bus.sv
hw/wb_ram.sv
hw/wb_gpio.sv
hw/reset_ctrl.sv
hw/soc_top.sv
verif/tb_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run from the project root, status follows the testbench result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc -o tb_soc \
  && ./obj_dir/tb_soc | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }
